// File: trap_chk_pkg.sv
// Trap-entry checker package with widths, mcause codes, exception kinds and slot states
package trap_chk_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Instruction addresses and mepc values are full 32 bit words
  localparam int PC_W = 32;

  // Width of the exception code field of mcause
  localparam int EXC_CODE_W = 5;

  // Number of exception kinds tracked by the checker
  localparam int NUM_EXC_KINDS = 5;

  // Program counter of a retiring instruction, also used for mepc
  typedef logic [PC_W-1:0] pc_t;

  // Exception code field as written by the CSR file on a trap
  typedef logic [EXC_CODE_W-1:0] exc_code_t;

  ////////////////////
  // Cause codes
  ////////////////////

  // Instruction access fault raised by the MPU
  localparam exc_code_t EXC_CODE_INSTR_FAULT = exc_code_t'(1);

  // Illegal instruction
  localparam exc_code_t EXC_CODE_ILLEGAL = exc_code_t'(2);

  // EBREAK outside of debug entry
  localparam exc_code_t EXC_CODE_BREAKPOINT = exc_code_t'(3);

  // ECALL from machine mode
  localparam exc_code_t EXC_CODE_ECALL_M = exc_code_t'(11);

  // Instruction fetch bus error, a custom code in the platform range
  localparam exc_code_t EXC_CODE_INSTR_BUS = exc_code_t'(24);

  ////////////////////
  // Exception kinds
  ////////////////////

  // One value per tracked exception kind
  // The numeric value doubles as the bit index in a kind mask
  // EXC_NONE marks a retiring instruction that records nothing
  typedef enum logic [2:0] {
    EXC_MPU     = 3'd0,
    EXC_BUS     = 3'd1,
    EXC_ILLEGAL = 3'd2,
    EXC_ECALL   = 3'd3,
    EXC_EBREAK  = 3'd4,
    EXC_NONE    = 3'd7
  } exc_kind_e;

  // One bit per exception kind, bit i belongs to the kind with value i
  typedef logic [NUM_EXC_KINDS-1:0] kind_mask_t;

  ////////////////////
  // Monitor slots
  ////////////////////

  // Per-kind state of the mepc monitor
  // EMPTY waits for the first save of the kind
  // CAPTURED holds the mepc and waits for the expected PC
  // CHECKED is final until reset
  typedef enum logic [1:0] {
    SLOT_EMPTY    = 2'd0,
    SLOT_CAPTURED = 2'd1,
    SLOT_CHECKED  = 2'd2
  } slot_state_e;

endpackage

// File: wb_exc_classifier.sv
// Writeback exception classifier with priority selection and a registered expected-exception record
`timescale 1ns/10ps

module wb_exc_classifier
  import trap_chk_pkg::*;
(
  input  logic      clk,
  input  logic      rst_ni,

  // Retiring instruction in writeback
  input  logic      wb_valid_i,
  input  pc_t       wb_pc_i,
  input  logic      wb_mpu_err_i,
  input  logic      wb_bus_err_i,
  input  logic      wb_illegal_i,
  input  logic      wb_ecall_i,
  input  logic      wb_ebreak_i,

  // Events that take priority over a synchronous exception
  input  logic      irq_ack_i,
  input  logic      debug_take_i,
  input  logic      nmi_trap_i,
  input  logic      debug_mode_i,

  // Expected exception record, valid for one cycle
  output logic      exp_valid_o,
  output exc_kind_e exp_kind_o,
  output pc_t       exp_pc_o
);

  // An interrupt, NMI or debug entry wins over anything in writeback
  logic      blocked;
  exc_kind_e prio_kind;
  exc_kind_e kind_d;

  assign blocked = irq_ack_i | debug_take_i | nmi_trap_i;

  ////////////////////
  // Priority select
  ////////////////////

  // Several flags may be set on one instruction
  // Only the one with the highest priority becomes the trap cause
  always_comb begin
    prio_kind = EXC_NONE;
    if (wb_mpu_err_i) begin
      prio_kind = EXC_MPU;
    end else if (wb_bus_err_i) begin
      prio_kind = EXC_BUS;
    end else if (wb_illegal_i) begin
      prio_kind = EXC_ILLEGAL;
    end else if (wb_ecall_i) begin
      prio_kind = EXC_ECALL;
    end else if (wb_ebreak_i) begin
      prio_kind = EXC_EBREAK;
    end
  end

  // In debug mode the core does not trap to the machine handler
  // EBREAK is the exception and is still recorded there
  // A lower kind is never promoted when the winning kind is blocked
  always_comb begin
    kind_d = EXC_NONE;
    if (wb_valid_i && !blocked) begin
      if (!debug_mode_i || (prio_kind == EXC_EBREAK)) begin
        kind_d = prio_kind;
      end
    end
  end

  ////////////////////
  // Record register
  ////////////////////

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      exp_valid_o <= 1'b0;
      exp_kind_o  <= EXC_NONE;
    end else begin
      exp_valid_o <= (kind_d != EXC_NONE);
      exp_kind_o  <= kind_d;
    end
  end

  // PC of the classified instruction
  always_ff @(posedge clk) begin
    exp_pc_o <= wb_pc_i;
  end

  // A record never stems from a cycle with an interrupt, NMI or debug entry
  // An MPU flag always wins and debug mode lets only EBREAK through
  a_record_follows_rules : assert property (
    @(posedge clk) disable iff (!rst_ni)
    exp_valid_o |-> (!$past(irq_ack_i || debug_take_i || nmi_trap_i) &&
                     (!$past(wb_mpu_err_i) || (exp_kind_o == EXC_MPU)) &&
                     (!$past(debug_mode_i) || (exp_kind_o == EXC_EBREAK)))
  ) else $error("exception record breaks the priority rules");

endmodule

// File: exc_record_table.sv
// Table of the first recorded writeback PC per exception kind with armed flags
`timescale 1ns/10ps

module exc_record_table
  import trap_chk_pkg::*;
(
  input  logic       clk,
  input  logic       rst_ni,

  // Record from the classifier
  input  logic       exp_valid_i,
  input  exc_kind_e  exp_kind_i,
  input  pc_t        exp_pc_i,

  // Recorded PCs towards the mepc monitor
  output kind_mask_t armed_o,
  output pc_t        exp_pcs_o [NUM_EXC_KINDS]
);

  kind_mask_t armed_q;
  kind_mask_t wr_en;

  // One-hot write enable for the kind of the record
  // A slot that already holds a PC keeps it until reset
  always_comb begin
    wr_en = '0;
    if (exp_valid_i && (exp_kind_i != EXC_NONE)) begin
      wr_en = kind_mask_t'(1) << exp_kind_i;
    end
    wr_en = wr_en & ~armed_q;
  end

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q <= '0;
    end else begin
      armed_q <= armed_q | wr_en;
    end
  end

  // A PC is written together with its armed bit
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_EXC_KINDS; k++) begin
      if (wr_en[k]) begin
        exp_pcs_o[k] <= exp_pc_i;
      end
    end
  end

  assign armed_o = armed_q;

  // First-only behaviour means an armed slot keeps its bit and its PC
  for (genvar k = 0; k < NUM_EXC_KINDS; k++) begin : g_slot_sticky
    a_armed_sticky : assert property (
      @(posedge clk) disable iff (!rst_ni)
      armed_q[k] |=> (armed_q[k] && (exp_pcs_o[k] == $past(exp_pcs_o[k])))
    ) else $error("armed slot changed without reset");
  end

endmodule

// File: mepc_save_monitor.sv
// Monitor of the CSR save-cause strobe that captures mepc per exception kind and checks it
`timescale 1ns/10ps

module mepc_save_monitor
  import trap_chk_pkg::*;
(
  input  logic       clk,
  input  logic       rst_ni,

  // Trap save from the CSR file
  input  logic       csr_save_cause_i,
  input  logic       cause_irq_i,
  input  exc_code_t  cause_code_i,
  input  pc_t        mepc_n_i,

  // Expected PCs from the record table
  input  kind_mask_t armed_i,
  input  pc_t        exp_pcs_i [NUM_EXC_KINDS],

  // Sticky results per kind
  output kind_mask_t checked_o,
  output kind_mask_t mismatch_o
);

  exc_kind_e   save_kind;
  kind_mask_t  save_hit;
  kind_mask_t  cap_en;
  kind_mask_t  chk_en;
  slot_state_e state_q [NUM_EXC_KINDS];
  slot_state_e state_d [NUM_EXC_KINDS];
  pc_t         mepc_q  [NUM_EXC_KINDS];

  ////////////////////
  // Cause decode
  ////////////////////

  // Map the mcause code back to the kind that should have trapped
  always_comb begin
    case (cause_code_i)
      EXC_CODE_INSTR_FAULT: save_kind = EXC_MPU;
      EXC_CODE_INSTR_BUS:   save_kind = EXC_BUS;
      EXC_CODE_ILLEGAL:     save_kind = EXC_ILLEGAL;
      EXC_CODE_ECALL_M:     save_kind = EXC_ECALL;
      EXC_CODE_BREAKPOINT:  save_kind = EXC_EBREAK;
      default:              save_kind = EXC_NONE;
    endcase
  end

  // Interrupt saves share the strobe but say nothing about exceptions
  always_comb begin
    save_hit = '0;
    if (csr_save_cause_i && !cause_irq_i && (save_kind != EXC_NONE)) begin
      save_hit = kind_mask_t'(1) << save_kind;
    end
  end

  ////////////////////
  // Slot FSMs
  ////////////////////

  always_comb begin
    for (int k = 0; k < NUM_EXC_KINDS; k++) begin
      cap_en[k]  = save_hit[k] && (state_q[k] == SLOT_EMPTY);
      chk_en[k]  = armed_i[k] && (state_q[k] == SLOT_CAPTURED);
      state_d[k] = state_q[k];
      case (state_q[k])
        SLOT_EMPTY:    if (cap_en[k]) state_d[k] = SLOT_CAPTURED;
        SLOT_CAPTURED: if (chk_en[k]) state_d[k] = SLOT_CHECKED;
        default:       state_d[k] = SLOT_CHECKED;
      endcase
    end
  end

  always_ff @(posedge clk, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < NUM_EXC_KINDS; k++) begin
        state_q[k] <= SLOT_EMPTY;
      end
      checked_o  <= '0;
      mismatch_o <= '0;
    end else begin
      for (int k = 0; k < NUM_EXC_KINDS; k++) begin
        state_q[k] <= state_d[k];
        // Compare once when the slot moves into CHECKED
        if (chk_en[k]) begin
          checked_o[k]  <= 1'b1;
          mismatch_o[k] <= (mepc_q[k] != exp_pcs_i[k]);
        end
      end
    end
  end

  // Only the first save of each kind is kept
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_EXC_KINDS; k++) begin
      if (cap_en[k]) begin
        mepc_q[k] <= mepc_n_i;
      end
    end
  end

  // A kind is only reported once the record table has armed it
  a_report_needs_armed : assert property (
    @(posedge clk) disable iff (!rst_ni)
    (((checked_o | mismatch_o) & ~armed_i) == '0)
  ) else $error("result reported for a kind that was never armed");

endmodule

// File: trap_checker.sv
// Trap-entry checker top level connecting classifier, record table and mepc monitor
`timescale 1ns/10ps

module trap_checker
  import trap_chk_pkg::*;
(
  input  logic       clk,
  input  logic       rst_ni,

  // Writeback stage
  input  logic       wb_valid_i,
  input  pc_t        wb_pc_i,
  input  logic       wb_mpu_err_i,
  input  logic       wb_bus_err_i,
  input  logic       wb_illegal_i,
  input  logic       wb_ecall_i,
  input  logic       wb_ebreak_i,

  // Controller priority events
  input  logic       irq_ack_i,
  input  logic       debug_take_i,
  input  logic       nmi_trap_i,
  input  logic       debug_mode_i,

  // CSR file trap save
  input  logic       csr_save_cause_i,
  input  logic       cause_irq_i,
  input  exc_code_t  cause_code_i,
  input  pc_t        mepc_n_i,

  // Sticky per-kind results
  output kind_mask_t checked_o,
  output kind_mask_t mismatch_o
);

  // Classifier to table
  logic       exp_valid;
  exc_kind_e  exp_kind;
  pc_t        exp_pc;

  // Table to monitor
  kind_mask_t armed;
  pc_t        exp_pcs [NUM_EXC_KINDS];

  ////////////////////
  // Producer
  ////////////////////

  wb_exc_classifier wb_exc_classifier_i (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .wb_valid_i   (wb_valid_i),
    .wb_pc_i      (wb_pc_i),
    .wb_mpu_err_i (wb_mpu_err_i),
    .wb_bus_err_i (wb_bus_err_i),
    .wb_illegal_i (wb_illegal_i),
    .wb_ecall_i   (wb_ecall_i),
    .wb_ebreak_i  (wb_ebreak_i),
    .irq_ack_i    (irq_ack_i),
    .debug_take_i (debug_take_i),
    .nmi_trap_i   (nmi_trap_i),
    .debug_mode_i (debug_mode_i),
    .exp_valid_o  (exp_valid),
    .exp_kind_o   (exp_kind),
    .exp_pc_o     (exp_pc)
  );

  ////////////////////
  // Buffer
  ////////////////////

  exc_record_table exc_record_table_i (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .exp_valid_i (exp_valid),
    .exp_kind_i  (exp_kind),
    .exp_pc_i    (exp_pc),
    .armed_o     (armed),
    .exp_pcs_o   (exp_pcs)
  );

  ////////////////////
  // Consumer
  ////////////////////

  mepc_save_monitor mepc_save_monitor_i (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .csr_save_cause_i (csr_save_cause_i),
    .cause_irq_i      (cause_irq_i),
    .cause_code_i     (cause_code_i),
    .mepc_n_i         (mepc_n_i),
    .armed_i          (armed),
    .exp_pcs_i        (exp_pcs),
    .checked_o        (checked_o),
    .mismatch_o       (mismatch_o)
  );

endmodule

// File: tb_trap_checker.sv
// Testbench for the trap-entry checker with file-driven stimulus, compare tasks and a cycle timeout
`timescale 1ns/10ps

module tb_trap_checker
  import trap_chk_pkg::*;
();

  logic       clk = 1'b0;
  logic       rst_ni;
  logic       wb_valid_i;
  pc_t        wb_pc_i;
  logic       wb_mpu_err_i;
  logic       wb_bus_err_i;
  logic       wb_illegal_i;
  logic       wb_ecall_i;
  logic       wb_ebreak_i;
  logic       irq_ack_i;
  logic       debug_take_i;
  logic       nmi_trap_i;
  logic       debug_mode_i;
  logic       csr_save_cause_i;
  logic       cause_irq_i;
  exc_code_t  cause_code_i;
  pc_t        mepc_n_i;
  kind_mask_t checked_o;
  kind_mask_t mismatch_o;

  // Error counters, one per kind of failure
  int checked_errs  = 0;
  int mismatch_errs = 0;
  int other_errs    = 0;
  int num_checks    = 0;

  // The limit stays 0 until the test file has been sized
  int cycle_cnt   = 0;
  int cycle_limit = 0;

  always #2 clk = ~clk;

  trap_checker trap_checker_i (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .wb_valid_i       (wb_valid_i),
    .wb_pc_i          (wb_pc_i),
    .wb_mpu_err_i     (wb_mpu_err_i),
    .wb_bus_err_i     (wb_bus_err_i),
    .wb_illegal_i     (wb_illegal_i),
    .wb_ecall_i       (wb_ecall_i),
    .wb_ebreak_i      (wb_ebreak_i),
    .irq_ack_i        (irq_ack_i),
    .debug_take_i     (debug_take_i),
    .nmi_trap_i       (nmi_trap_i),
    .debug_mode_i     (debug_mode_i),
    .csr_save_cause_i (csr_save_cause_i),
    .cause_irq_i      (cause_irq_i),
    .cause_code_i     (cause_code_i),
    .mepc_n_i         (mepc_n_i),
    .checked_o        (checked_o),
    .mismatch_o       (mismatch_o)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
      $display("run timed out after %0d cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////
  // Drivers
  ////////////////////

  // Quiet bus, nothing retires and nothing is saved
  task automatic drive_idle();
    wb_valid_i       <= 1'b0;
    wb_pc_i          <= '0;
    wb_mpu_err_i     <= 1'b0;
    wb_bus_err_i     <= 1'b0;
    wb_illegal_i     <= 1'b0;
    wb_ecall_i       <= 1'b0;
    wb_ebreak_i      <= 1'b0;
    irq_ack_i        <= 1'b0;
    debug_take_i     <= 1'b0;
    nmi_trap_i       <= 1'b0;
    debug_mode_i     <= 1'b0;
    csr_save_cause_i <= 1'b0;
    cause_irq_i      <= 1'b0;
    cause_code_i     <= '0;
    mepc_n_i         <= '0;
  endtask

  // Exception flags use the kind index as bit position
  // Priority flags are irq_ack, debug_take, nmi and debug_mode from bit 0 up
  task automatic apply_writeback(input logic [7:0] exc, input logic [7:0] prio, input pc_t pc);
    @(posedge clk);
    wb_valid_i   <= 1'b1;
    wb_pc_i      <= pc;
    wb_mpu_err_i <= exc[0];
    wb_bus_err_i <= exc[1];
    wb_illegal_i <= exc[2];
    wb_ecall_i   <= exc[3];
    wb_ebreak_i  <= exc[4];
    irq_ack_i    <= prio[0];
    debug_take_i <= prio[1];
    nmi_trap_i   <= prio[2];
    debug_mode_i <= prio[3];
    @(posedge clk);
    drive_idle();
  endtask

  task automatic apply_save(input logic irq, input exc_code_t code, input pc_t mepc);
    @(posedge clk);
    csr_save_cause_i <= 1'b1;
    cause_irq_i      <= irq;
    cause_code_i     <= code;
    mepc_n_i         <= mepc;
    @(posedge clk);
    drive_idle();
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_ni <= 1'b0;
    repeat (4) @(posedge clk);
    rst_ni <= 1'b1;
  endtask

  // Random spacing between events, the result must not depend on it
  task automatic idle_gap();
    int gap;
    gap = int'($urandom % 32'd4);
    repeat (gap) @(posedge clk);
  endtask

  ////////////////////
  // Checks
  ////////////////////

  task automatic compare_checked(input kind_mask_t exp);
    if (checked_o !== exp) begin
      $display("mismatch checked_o: got %h expected %h", checked_o, exp);
      checked_errs++;
    end
  endtask

  task automatic compare_mismatch(input kind_mask_t exp);
    if (mismatch_o !== exp) begin
      $display("mismatch mismatch_o: got %h expected %h", mismatch_o, exp);
      mismatch_errs++;
    end
  endtask

  // Four idle cycles cover the full path from writeback to checked_o
  // Outputs are sampled on the falling edge, away from the register updates
  task automatic check_outputs(input kind_mask_t exp_chk, input kind_mask_t exp_mis);
    repeat (4) @(posedge clk);
    @(negedge clk);
    compare_checked(exp_chk);
    compare_mismatch(exp_mis);
    num_checks++;
  endtask

  task automatic run_command(input string line);
    logic [7:0]  cmd;
    int          nf;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    cmd = 8'h0a;
    if (line.len() > 0) begin
      cmd = line.getc(0);
    end
    nf = 0;
    case (cmd)
      "W": nf = $sscanf(line, "W %h %h %h", a, b, c);
      "S": nf = $sscanf(line, "S %h %h %h", a, b, c);
      "E": nf = $sscanf(line, "E %h %h", a, b);
      default: nf = 0;
    endcase
    if ((cmd == "W") && (nf == 3)) begin
      apply_writeback(a[7:0], b[7:0], c);
      idle_gap();
    end else if ((cmd == "S") && (nf == 3)) begin
      apply_save(a[0], exc_code_t'(b), c);
      idle_gap();
    end else if ((cmd == "E") && (nf == 2)) begin
      check_outputs(kind_mask_t'(a), kind_mask_t'(b));
    end else if (cmd == "R") begin
      apply_reset();
    end else if ((cmd != "#") && (cmd != 8'h0a) && (cmd != 8'h0d)) begin
      $display("test file line could not be understood: %s", line);
      other_errs++;
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int    fd;
    int    nlines;
    string line;
    void'($urandom(61422));
    drive_idle();
    rst_ni <= 1'b0;
    nlines = 0;
    fd = $fopen("trap_checker_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open trap_checker_tests.txt");
      other_errs++;
    end else begin
      // First pass only sizes the timeout
      while ($fgets(line, fd) != 0) begin
        nlines++;
      end
      $fclose(fd);
      cycle_limit = 20 * nlines;
      repeat (4) @(posedge clk);
      rst_ni <= 1'b1;
      fd = $fopen("trap_checker_tests.txt", "r");
      while ($fgets(line, fd) != 0) begin
        run_command(line);
      end
      $fclose(fd);
    end
    if (num_checks == 0) begin
      $display("no expected values were compared");
      other_errs++;
    end
    $display("errors: checked_o %0d, mismatch_o %0d, other %0d, in %0d checks",
             checked_errs, mismatch_errs, other_errs, num_checks);
    if ((checked_errs + mismatch_errs + other_errs) == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: trap_checker_tests.txt
# W <exc flags: b0 mpu b1 bus b2 illegal b3 ecall b4 ebreak> <prio: b0 irq b1 dbg_take b2 nmi b3 dbg_mode> <pc>
# S <irq> <cause code> <mepc>, E <checked> <mismatch>, R resets for 4 cycles; all values hex
# Illegal instruction with matching mepc
W 04 0 00001000
S 0 02 00001000
E 04 00
# ECALL with a wrong mepc
W 08 0 00001010
S 0 0b 00001014
E 0c 08
# Reset clears both masks
R
E 00 00
# MPU wins over illegal, the illegal save stays unchecked
W 05 0 00002000
S 0 02 00002000
S 0 01 00002000
E 01 00
# Bus errors lost to irq, debug entry and NMI
W 02 1 00003000
W 02 2 00003000
W 02 4 00003000
S 0 18 00003000
E 01 00
# ECALL in debug mode records nothing
W 08 8 00003100
S 0 0b 00003100
E 01 00
# Interrupt save is ignored, EBREAK in debug mode is recorded
S 1 03 00003300
W 10 8 00003200
E 01 00
S 0 03 00003200
E 11 00
W 02 0 00003000
E 13 00
# Second EBREAK pair changes nothing
W 10 0 00003400
S 0 03 00003404
E 13 00
# First-only with the record before the save
R
W 10 0 00004000
W 10 0 00004100
S 0 03 00004000
S 0 03 00004100
E 10 00
# First-only with the save before the record
R
S 0 03 00005004
S 0 03 00005000
W 10 0 00005000
W 10 0 00005100
E 10 10
R
E 00 00

// File: sources.f
trap_chk_pkg.sv
wb_exc_classifier.sv
exc_record_table.sv
mepc_save_monitor.sv
trap_checker.sv
tb_trap_checker.sv

// File: Makefile
# Verilator simulation of the trap-entry checker
VERILATOR ?= verilator
TOP       := tb_trap_checker
RTL_TOP   := trap_checker
FILELIST  := sources.f
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/10ps
BUILD_DIR := obj_dir
LOG       := sim.log
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: run build lint clean

run: build
	./$(SIM) | tee $(LOG)
	@grep -q '^TEST OK$$' $(LOG)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
